//--- Bender.yml
package:
  name: mempool_cluster

sources:
  - files:
      - mempool_pkg.sv
      - tcdm_fifo.sv
      - rr_arbiter.sv
      - tcdm_master.sv
      - numa_interconnect.sv
      - tcdm_bank.sv
      - mempool_cluster.sv
  - target: test
    files:
      - tb_mempool_cluster.sv

//--- mempool_cluster.sv
// MemPool cluster top connecting the core masters, the NUMA interconnect and the banks
`timescale 1ns/1ps

module mempool_cluster (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  logic                    [mempool_pkg::NumCores-1:0] cmd_valid_i,
  input  mempool_pkg::core_req_t  [mempool_pkg::NumCores-1:0] cmd_i,
  output logic                    [mempool_pkg::NumCores-1:0] cmd_ready_o,
  output logic                    [mempool_pkg::NumCores-1:0] resp_valid_o,
  output mempool_pkg::core_resp_t [mempool_pkg::NumCores-1:0] resp_o,
  input  logic                    [mempool_pkg::NumCores-1:0] resp_ready_i
);

  import mempool_pkg::*;

  // Master to interconnect
  logic       [NumCores-1:0] tcdm_req_valid;
  core_req_t  [NumCores-1:0] tcdm_req;
  logic       [NumCores-1:0] tcdm_gnt;
  logic       [NumCores-1:0] tcdm_resp_valid;
  core_resp_t [NumCores-1:0] tcdm_resp;

  // Interconnect to banks
  logic       [NumBanks-1:0] bank_req_valid;
  bank_req_t  [NumBanks-1:0] bank_req;
  logic       [NumBanks-1:0] bank_gnt;
  logic       [NumBanks-1:0] bank_resp_valid;
  bank_resp_t [NumBanks-1:0] bank_resp;
  logic       [NumBanks-1:0] bank_resp_ready;

  for (genvar c = 0; c < NumCores; c++) begin : gen_masters
    tcdm_master i_master (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .cmd_valid_i     (cmd_valid_i[c]),
      .cmd_i           (cmd_i[c]),
      .cmd_ready_o     (cmd_ready_o[c]),
      .resp_valid_o    (resp_valid_o[c]),
      .resp_o          (resp_o[c]),
      .resp_ready_i    (resp_ready_i[c]),
      .req_valid_o     (tcdm_req_valid[c]),
      .req_o           (tcdm_req[c]),
      .gnt_i           (tcdm_gnt[c]),
      .ic_resp_valid_i (tcdm_resp_valid[c]),
      .ic_resp_i       (tcdm_resp[c])
    );
  end : gen_masters

  numa_interconnect i_interco (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .req_valid_i       (tcdm_req_valid),
    .req_i             (tcdm_req),
    .gnt_o             (tcdm_gnt),
    .resp_valid_o      (tcdm_resp_valid),
    .resp_o            (tcdm_resp),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_o        (bank_req),
    .bank_gnt_i        (bank_gnt),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_i       (bank_resp),
    .bank_resp_ready_o (bank_resp_ready)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_valid_i  (bank_req_valid[b]),
      .req_i        (bank_req[b]),
      .gnt_o        (bank_gnt[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_o       (bank_resp[b]),
      .resp_ready_i (bank_resp_ready[b])
    );
  end : gen_banks

endmodule : mempool_cluster

//--- mempool_pkg.sv
// MemPool cluster package holding the cluster sizes and the shared TCDM request and response types
package mempool_pkg;

  // Cluster dimensions
  localparam int unsigned NumCores       = 4;
  localparam int unsigned NumBanks       = 4;
  localparam int unsigned NumOutstanding = 2;
  localparam int unsigned BankFifoDepth  = 2;

  // Word address split into bank select (low bits) and bank row
  localparam int unsigned AddrWidth    = 8;
  localparam int unsigned BankSelWidth = 2;
  localparam int unsigned RowWidth     = 6;
  localparam int unsigned BankWords    = 2 ** RowWidth;

  // Data path
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Bookkeeping fields
  localparam int unsigned TagWidth    = 4;
  localparam int unsigned CoreIdWidth = 2;
  localparam int unsigned CreditWidth = $clog2(NumOutstanding + 1);

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     be_t;
  typedef logic [RowWidth-1:0]    row_t;
  typedef logic [TagWidth-1:0]    tag_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;
  typedef logic [CreditWidth-1:0] credit_t;

  // Request as issued by a core
  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    be_t   be;
    tag_t  tag;
  } core_req_t;

  // Response as seen by a core, write acks carry wen set
  typedef struct packed {
    data_t rdata;
    logic  wen;
    tag_t  tag;
  } core_resp_t;

  // Request at a bank, ini routes the response back
  typedef struct packed {
    row_t     row;
    logic     wen;
    data_t    wdata;
    be_t      be;
    tag_t     tag;
    core_id_t ini;
  } bank_req_t;

  typedef struct packed {
    data_t    rdata;
    logic     wen;
    tag_t     tag;
    core_id_t ini;
  } bank_resp_t;

endpackage : mempool_pkg

//--- numa_interconnect.sv
// NUMA interconnect routing core requests to banks and bank responses back to cores
`timescale 1ns/1ps

module numa_interconnect (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  // Core side
  input  logic                    [mempool_pkg::NumCores-1:0] req_valid_i,
  input  mempool_pkg::core_req_t  [mempool_pkg::NumCores-1:0] req_i,
  output logic                    [mempool_pkg::NumCores-1:0] gnt_o,
  output logic                    [mempool_pkg::NumCores-1:0] resp_valid_o,
  output mempool_pkg::core_resp_t [mempool_pkg::NumCores-1:0] resp_o,
  // Bank side
  output logic                    [mempool_pkg::NumBanks-1:0] bank_req_valid_o,
  output mempool_pkg::bank_req_t  [mempool_pkg::NumBanks-1:0] bank_req_o,
  input  logic                    [mempool_pkg::NumBanks-1:0] bank_gnt_i,
  input  logic                    [mempool_pkg::NumBanks-1:0] bank_resp_valid_i,
  input  mempool_pkg::bank_resp_t [mempool_pkg::NumBanks-1:0] bank_resp_i,
  output logic                    [mempool_pkg::NumBanks-1:0] bank_resp_ready_o
);

  import mempool_pkg::*;

  logic [NumBanks-1:0][NumCores-1:0] bank_arb_req;
  logic [NumBanks-1:0][NumCores-1:0] bank_arb_gnt;
  logic [NumCores-1:0][NumBanks-1:0] resp_arb_req;
  logic [NumCores-1:0][NumBanks-1:0] resp_arb_gnt;

  // Request path, one arbiter per bank
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_port
    bank_req_t req_mux;

    // Bank is picked by the low word address bits
    for (genvar c = 0; c < NumCores; c++) begin : gen_bank_req
      assign bank_arb_req[b][c] = req_valid_i[c] &&
          (req_i[c].addr[BankSelWidth-1:0] == BankSelWidth'(b));
    end

    rr_arbiter #(
      .NumReq (NumCores)
    ) i_req_arb (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (bank_arb_req[b]),
      .advance_i (bank_gnt_i[b]),
      .gnt_o     (bank_arb_gnt[b])
    );

    always_comb begin
      req_mux = '0;
      for (int unsigned c = 0; c < NumCores; c++) begin
        if (bank_arb_gnt[b][c]) begin
          req_mux.row   = req_i[c].addr[BankSelWidth +: RowWidth];
          req_mux.wen   = req_i[c].wen;
          req_mux.wdata = req_i[c].wdata;
          req_mux.be    = req_i[c].be;
          req_mux.tag   = req_i[c].tag;
          req_mux.ini   = core_id_t'(c);
        end
      end
    end

    assign bank_req_valid_o[b] = |bank_arb_req[b];
    assign bank_req_o[b]       = req_mux;
  end : gen_bank_port

  // A core is granted when its bank arbiter picked it and the bank has room
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      gnt_o |= bank_arb_gnt[b] & {NumCores{bank_gnt_i[b]}};
    end
  end

  // Response path, one arbiter per core over banks holding its responses
  for (genvar c = 0; c < NumCores; c++) begin : gen_core_port
    core_resp_t resp_mux;

    for (genvar b = 0; b < NumBanks; b++) begin : gen_resp_req
      assign resp_arb_req[c][b] = bank_resp_valid_i[b] &&
          (bank_resp_i[b].ini == core_id_t'(c));
    end

    // Master always has room, so every grant is used
    rr_arbiter #(
      .NumReq (NumBanks)
    ) i_resp_arb (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (resp_arb_req[c]),
      .advance_i (1'b1),
      .gnt_o     (resp_arb_gnt[c])
    );

    always_comb begin
      resp_mux = '0;
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (resp_arb_gnt[c][b]) begin
          resp_mux.rdata = bank_resp_i[b].rdata;
          resp_mux.wen   = bank_resp_i[b].wen;
          resp_mux.tag   = bank_resp_i[b].tag;
        end
      end
    end

    assign resp_valid_o[c] = |resp_arb_req[c];
    assign resp_o[c]       = resp_mux;
  end : gen_core_port

  always_comb begin
    bank_resp_ready_o = '0;
    for (int unsigned c = 0; c < NumCores; c++) begin
      bank_resp_ready_o |= resp_arb_gnt[c];
    end
  end

endmodule : numa_interconnect

//--- rr_arbiter.sv
// Round-robin arbiter with a rotating priority pointer and one-hot grant
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumReq   = 4,
  parameter int unsigned PtrWidth = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              advance_i,
  output logic [NumReq-1:0] gnt_o
);

  logic [PtrWidth-1:0] prio_q;
  logic [PtrWidth-1:0] win_idx;

  // First requester at or after the priority pointer wins
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o   = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      idx = (int'(prio_q) + i) % NumReq;
      if (!found && req_i[idx]) begin
        found        = 1'b1;
        gnt_o[idx]   = 1'b1;
        win_idx      = PtrWidth'(idx);
      end
    end
  end

  // Pointer moves just past the winner once the grant was taken
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= '0;
    end else if (advance_i && |gnt_o) begin
      prio_q <= (win_idx == PtrWidth'(NumReq - 1)) ? '0 : win_idx + 1'b1;
    end
  end

endmodule : rr_arbiter

//--- tb_mempool_cluster.sv
// Testbench for the MemPool cluster with a reference memory model and response checking
`timescale 1ns/1ps

module tb_mempool_cluster;

  import mempool_pkg::*;

  // About 380 commands per core, at worst about 50 cycles each under contention
  localparam int unsigned CycleLimit = 20000;

  logic                        clk_i;
  logic                        reset_i;
  logic       [NumCores-1:0]   cmd_valid_i;
  core_req_t  [NumCores-1:0]   cmd_i;
  logic       [NumCores-1:0]   cmd_ready_o;
  logic       [NumCores-1:0]   resp_valid_o;
  core_resp_t [NumCores-1:0]   resp_o;
  logic       [NumCores-1:0]   resp_ready_i;

  // Reference state
  data_t      ref_mem [2**AddrWidth];
  core_resp_t exp_resp [NumCores][2**TagWidth];
  logic       exp_pending [NumCores][2**TagWidth];
  tag_t       next_tag [NumCores];
  int         issued [NumCores];
  int         received [NumCores];
  int         ready_mode [NumCores];
  logic [31:0] lfsr_q [2*NumCores];
  core_req_t  first_req [NumCores];
  string      test_name;
  int         err_value;
  int         err_other;
  int         cycle_cnt;

  mempool_cluster DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_ready_o  (cmd_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

  always #2 clk_i = ~clk_i;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int s, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val      = {val[30:0], lfsr_q[s][31]};
      lfsr_q[s] = lfsr_next(lfsr_q[s]);
    end
  endtask

  // Word owned by a core, row low bits hold the core id and idx[1:0] picks the bank
  function automatic addr_t own_addr(input int c, input int idx);
    return addr_t'({idx[5:2], 2'(c), idx[1:0]});
  endfunction

  function automatic core_req_t make_req(input addr_t addr, input logic wen,
                                         input data_t wdata, input be_t be);
    core_req_t req;
    req.addr  = addr;
    req.wen   = wen;
    req.wdata = wdata;
    req.be    = be;
    req.tag   = '0;
    return req;
  endfunction

  // Memory model, applied in acceptance order which matches bank FIFO order
  function automatic core_resp_t ref_access(input core_req_t req);
    core_resp_t resp;
    data_t      word;
    word     = ref_mem[req.addr];
    resp.tag = req.tag;
    resp.wen = req.wen;
    if (req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (req.be[i]) begin
          word[8*i +: 8] = req.wdata[8*i +: 8];
        end
      end
      ref_mem[req.addr] = word;
      resp.rdata = '0;
    end else begin
      resp.rdata = word;
    end
    return resp;
  endfunction

  task automatic record_accept(input int c, input core_req_t req);
    if (exp_pending[c][req.tag]) begin
      $display("Core %0d reused tag %0d while it was still outstanding", c, req.tag);
      err_other++;
    end
    exp_resp[c][req.tag]    = ref_access(req);
    exp_pending[c][req.tag] = 1'b1;
    issued[c]++;
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_cmd(input int c, input core_req_t req);
    logic done;
    done    = 1'b0;
    req.tag = next_tag[c];
    next_tag[c]++;
    cmd_i[c]       = req;
    cmd_valid_i[c] = 1'b1;
    while (!done) begin
      @(negedge clk_i);
      if (cmd_ready_o[c]) begin
        record_accept(c, req);
        done = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    cmd_valid_i[c] = 1'b0;
  endtask

  task automatic run_phase(input int c, input int which);
    logic [31:0] idx;
    logic [31:0] data;
    logic [31:0] be;
    logic [31:0] wen;
    case (which)
      2: begin
        for (int i = 0; i < 64; i++) begin
          take_bits(c, 32, data);
          send_cmd(c, make_req(own_addr(c, i), 1'b1, data, 4'hF));
        end
        for (int i = 0; i < 64; i++) begin
          send_cmd(c, make_req(own_addr(c, i), 1'b0, '0, '0));
        end
      end
      3: begin
        for (int i = 0; i < 16; i++) begin
          take_bits(c, 6, idx);
          take_bits(c, 32, data);
          take_bits(c, 4, be);
          send_cmd(c, make_req(own_addr(c, idx), 1'b1, data, be[3:0]));
          send_cmd(c, make_req(own_addr(c, idx), 1'b0, '0, '0));
        end
      end
      5: begin
        // Every core aims at bank 2
        for (int k = 0; k < 8; k++) begin
          take_bits(c, 32, data);
          send_cmd(c, make_req(own_addr(c, 4*k + 2), 1'b1, data, 4'hF));
          send_cmd(c, make_req(own_addr(c, 4*k + 2), 1'b0, '0, '0));
        end
      end
      default: begin
        for (int i = 0; i < 200; i++) begin
          take_bits(c, 6, idx);
          take_bits(c, 1, wen);
          take_bits(c, 32, data);
          take_bits(c, 4, be);
          send_cmd(c, make_req(own_addr(c, idx), wen[0], data, be[3:0]));
        end
      end
    endcase
  endtask

  task automatic run_all(input int which);
    for (int c = 0; c < NumCores; c++) begin
      automatic int cc = c;
      fork
        run_phase(cc, which);
      join_none
    end
    wait fork;
  endtask

  // Waits for all outstanding responses, then checks counts
  task automatic drain(input int limit);
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy && waited < limit) begin
      @(posedge clk_i);
      #1;
      waited++;
      busy = 1'b0;
      for (int c = 0; c < NumCores; c++) begin
        if (received[c] != issued[c]) begin
          busy = 1'b1;
        end
      end
    end
    for (int c = 0; c < NumCores; c++) begin
      if (received[c] < issued[c]) begin
        $display("%s: core %0d is missing %0d responses", test_name, c,
                 issued[c] - received[c]);
        err_other++;
      end
      if (received[c] > issued[c]) begin
        $display("%s: core %0d got %0d more responses than commands", test_name, c,
                 received[c] - issued[c]);
        err_other++;
      end
    end
  endtask

  // Response ready per core: low, high or random
  always @(posedge clk_i) begin
    logic [31:0] bit_val;
    #1;
    for (int c = 0; c < NumCores; c++) begin
      if (ready_mode[c] == 0) begin
        resp_ready_i[c] = 1'b0;
      end else if (ready_mode[c] == 1) begin
        resp_ready_i[c] = 1'b1;
      end else begin
        take_bits(NumCores + c, 1, bit_val);
        resp_ready_i[c] = bit_val[0];
      end
    end
  end

  // Compare popped responses against the expected table
  always @(negedge clk_i) begin
    core_resp_t got;
    core_resp_t want;
    if (!reset_i) begin
      for (int c = 0; c < NumCores; c++) begin
        if (resp_valid_o[c] && resp_ready_i[c]) begin
          got = resp_o[c];
          if (!exp_pending[c][got.tag]) begin
            $display("%s: core %0d returned tag %0d which was not outstanding",
                     test_name, c, got.tag);
            err_other++;
          end else begin
            want = exp_resp[c][got.tag];
            if (got.wen !== want.wen) begin
              $display("FAIL %s core %0d tag %0d wen expected %b actual %b",
                       test_name, c, got.tag, want.wen, got.wen);
              err_value++;
            end
            if (got.rdata !== want.rdata) begin
              $display("FAIL %s core %0d tag %0d rdata expected %h actual %h",
                       test_name, c, got.tag, want.rdata, got.rdata);
              err_value++;
            end
            exp_pending[c][got.tag] = 1'b0;
          end
          received[c]++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("Timeout after %0d cycles, the tests did not complete", CycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    cmd_valid_i  = '0;
    cmd_i        = '0;
    resp_ready_i = '0;
    err_value    = 0;
    err_other    = 0;
    cycle_cnt    = 0;
    test_name    = "reset";
    for (int s = 0; s < 2 * NumCores; s++) begin
      lfsr_q[s] = 32'd88834;
      repeat (97 * s) lfsr_q[s] = lfsr_next(lfsr_q[s]);
    end
    for (int c = 0; c < NumCores; c++) begin
      next_tag[c]   = '0;
      issued[c]     = 0;
      received[c]   = 0;
      ready_mode[c] = 1;
      for (int t = 0; t < 2**TagWidth; t++) begin
        exp_pending[c][t] = 1'b0;
      end
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // 1: idle outputs, then one command per core to distinct banks
    test_name = "after_reset";
    @(negedge clk_i);
    if (resp_valid_o !== '0) begin
      $display("FAIL %s resp_valid_o expected %b actual %b", test_name, 4'b0, resp_valid_o);
      err_value++;
    end
    @(posedge clk_i);
    #1;
    for (int c = 0; c < NumCores; c++) begin
      first_req[c]     = make_req(own_addr(c, c), 1'b1, 32'hA5A5_0000 + c, 4'hF);
      first_req[c].tag = next_tag[c];
      next_tag[c]++;
      cmd_i[c] = first_req[c];
    end
    cmd_valid_i = '1;
    @(negedge clk_i);
    if (cmd_ready_o !== '1) begin
      $display("FAIL %s cmd_ready_o expected %b actual %b", test_name, 4'hF, cmd_ready_o);
      err_value++;
    end
    for (int c = 0; c < NumCores; c++) begin
      if (cmd_ready_o[c]) begin
        record_accept(c, first_req[c]);
      end
    end
    @(posedge clk_i);
    #1;
    cmd_valid_i = '0;
    drain(200);

    test_name = "write_read";
    run_all(2);
    drain(200);

    test_name = "partial_write";
    run_all(3);
    drain(200);

    // 4: core 0 runs out of credits while its responses are held back
    test_name  = "credit_limit";
    ready_mode[0] = 0;
    for (int k = 0; k < NumOutstanding; k++) begin
      send_cmd(0, make_req(own_addr(0, k), 1'b0, '0, '0));
    end
    fork
      send_cmd(0, make_req(own_addr(0, 2), 1'b0, '0, '0));
      begin
        repeat (20) begin
          @(negedge clk_i);
          if (cmd_ready_o[0] !== 1'b0) begin
            $display("FAIL %s core 0 cmd_ready_o expected %b actual %b",
                     test_name, 1'b0, cmd_ready_o[0]);
            err_value++;
          end
        end
        ready_mode[0] = 1;
      end
    join
    drain(200);

    test_name = "bank_conflict";
    run_all(5);
    drain(200);

    test_name = "random_traffic";
    for (int c = 0; c < NumCores; c++) begin
      ready_mode[c] = 2;
    end
    run_all(6);
    drain(1000);
    for (int c = 0; c < NumCores; c++) begin
      ready_mode[c] = 1;
    end

    $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_mempool_cluster

//--- tcdm_bank.sv
// TCDM memory bank with request FIFO, byte-enabled storage and held response register
`timescale 1ns/1ps

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  mempool_pkg::bank_req_t  req_i,
  output logic                    gnt_o,
  output logic                    resp_valid_o,
  output mempool_pkg::bank_resp_t resp_o,
  input  logic                    resp_ready_i
);

  import mempool_pkg::*;

  bank_req_t  head;
  logic       fifo_full;
  logic       fifo_empty;
  logic       serve;
  logic       resp_valid_q;
  bank_resp_t resp_q;
  data_t      mem_q [BankWords];

  assign gnt_o = !fifo_full;

  tcdm_fifo #(
    .Depth     (BankFifoDepth),
    .payload_t (bank_req_t)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (req_valid_i && gnt_o),
    .data_i  (req_i),
    .full_o  (fifo_full),
    .pop_i   (serve),
    .data_o  (head),
    .empty_o (fifo_empty)
  );

  // Serve the head when the response slot is free or drains this cycle
  assign serve = !fifo_empty && (!resp_valid_q || resp_ready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (serve) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Storage access and response capture
  always_ff @(posedge clk_i) begin
    if (serve) begin
      if (head.wen) begin
        for (int unsigned i = 0; i < BeWidth; i++) begin
          if (head.be[i]) begin
            mem_q[head.row][8*i +: 8] <= head.wdata[8*i +: 8];
          end
        end
      end
      resp_q.rdata <= head.wen ? '0 : mem_q[head.row];
      resp_q.wen   <= head.wen;
      resp_q.tag   <= head.tag;
      resp_q.ini   <= head.ini;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule : tcdm_bank

//--- tcdm_fifo.sv
// Synchronous circular-buffer FIFO with a configurable payload type
`timescale 1ns/1ps

module tcdm_fifo #(
  parameter int unsigned Depth      = 2,
  parameter type         payload_t  = logic,
  parameter int unsigned PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1,
  parameter int unsigned CountWidth = $clog2(Depth + 1)
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  payload_t                mem_q [Depth];
  logic [PtrWidth-1:0]     rd_ptr_q;
  logic [PtrWidth-1:0]     wr_ptr_q;
  logic [CountWidth-1:0]   count_q;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count_q == CountWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Requests against a full or empty buffer are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : tcdm_fifo

//--- tcdm_master.sv
// Per-core TCDM request master with credit-based flow control and a response FIFO
`timescale 1ns/1ps

module tcdm_master (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Command side from the core
  input  logic                   cmd_valid_i,
  input  mempool_pkg::core_req_t cmd_i,
  output logic                   cmd_ready_o,
  // Response side to the core
  output logic                    resp_valid_o,
  output mempool_pkg::core_resp_t resp_o,
  input  logic                    resp_ready_i,
  // Interconnect request port
  output logic                   req_valid_o,
  output mempool_pkg::core_req_t req_o,
  input  logic                   gnt_i,
  // Interconnect response port, no back-pressure
  input  logic                    ic_resp_valid_i,
  input  mempool_pkg::core_resp_t ic_resp_i
);

  import mempool_pkg::*;

  credit_t credit_q;
  logic    has_credit;
  logic    req_taken;
  logic    resp_pop;
  logic    fifo_empty;

  assign has_credit = (credit_q != '0);

  // Commands go straight to the interconnect while a credit is held
  assign req_valid_o = cmd_valid_i && has_credit;
  assign req_o       = cmd_i;
  assign cmd_ready_o = has_credit && gnt_i;

  assign req_taken = req_valid_o && gnt_i;
  assign resp_pop  = resp_valid_o && resp_ready_i;

  // One credit per reserved slot in the response FIFO
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q <= credit_t'(NumOutstanding);
    end else begin
      case ({req_taken, resp_pop})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Never overflows since every slot is backed by a credit
  tcdm_fifo #(
    .Depth     (NumOutstanding),
    .payload_t (core_resp_t)
  ) i_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (ic_resp_valid_i),
    .data_i  (ic_resp_i),
    .full_o  (),
    .pop_i   (resp_pop),
    .data_o  (resp_o),
    .empty_o (fifo_empty)
  );

  assign resp_valid_o = !fifo_empty;

endmodule : tcdm_master

//--- verilog.f
mempool_pkg.sv
tcdm_fifo.sv
rr_arbiter.sv
tcdm_master.sv
numa_interconnect.sv
tcdm_bank.sv
mempool_cluster.sv
tb_mempool_cluster.sv
